// ==== design/predecodePkg.sv ====
// shared widths, lane counts, class bit indices and opcode groups for the predecoder RTL
package predecodePkg;

  // bundle geometry
  localparam int nSlots = 15;  // halfword slots per bundle
  localparam int slotW  = 16;
  localparam int instrW = 64;  // four halfwords from the start slot
  localparam int offW   = 4;

  // output lanes
  localparam int nInstrLanes = 12;
  localparam int nJumpLanes  = 4;

  // class vector
  localparam int clsW = 8;

  localparam int clsJump  = 0;
  localparam int clsIndir = 1;
  localparam int clsAlu   = 2;
  localparam int clsShift = 3;
  localparam int clsMul   = 4;
  localparam int clsLoad  = 5;
  localparam int clsStore = 6;
  localparam int clsSys   = 7;

  // decoded opcode groups, long form first, then the one-halfword forms
  typedef enum logic [3:0] {
    opNone,
    opAlu,
    opMul,
    opShift,
    opCmp,
    opMem,
    opCondJump,
    opLongJump,
    opBranchGroup,
    opSys,
    opShortAlu,
    opShortShift,
    opShortJump
  } opGroupT;

endpackage

// ==== design/instrClassifier.sv ====
`timescale 1ns/1ns
// combinational class decode of the instruction starting at one slot, one copy per slot
module instrClassifier import predecodePkg::*; (
  input  logic [instrW-1:0] instr,
  input  logic [3:0]        magic,
  output logic [clsW-1:0]   cls
);

  logic [7:0] opMain;
  logic [5:0] opSub;
  logic [2:0] brSub;
  logic       isLong;
  opGroupT    group;

  assign opMain = instr[7:0];
  assign opSub  = instr[5:0];
  assign brSub  = instr[15:13];  // branch group sub-field
  assign isLong = magic[0];      // own end bit clear

  // opcode group
  always_comb begin
    group = opNone;
    if (isLong) begin
      if (opMain < 8'd40) begin
        group = opMain[2] ? opMul : opAlu;
      end else if (opMain <= 8'd45) begin
        group = opShift;
      end else if (opMain <= 8'd51) begin
        group = opCmp;
      end else if (opMain >= 8'd64 && opMain <= 8'd111) begin
        group = opMem;
      end else if (opMain[7:4] == 4'ha) begin
        group = opCondJump;  // 160..175
      end else if (opMain == 8'd180 || opMain == 8'd181) begin
        group = opLongJump;
      end else if (opMain == 8'd182) begin
        group = opBranchGroup;
      end else if (opMain == 8'hff) begin
        group = opSys;
      end
    end else begin
      if (opSub < 6'd16) begin
        group = opShortAlu;
      end else if (opSub >= 6'd48 && opSub <= 6'd51) begin
        group = opShortJump;
      end else if (opSub < 6'd32 && opSub[0]) begin
        group = opShortShift;
      end
    end
  end

  // group to class bits
  always_comb begin
    cls = '0;
    case (group)
      opAlu: begin
        cls[clsAlu] = 1'b1;
      end
      opMul: begin
        cls[clsMul] = 1'b1;
      end
      opShift: begin
        cls[clsShift] = 1'b1;
      end
      opCmp: begin
        cls[clsAlu] = 1'b1;  // compares go down the ALU pipe
      end
      opMem: begin
        cls[clsLoad]  = ~opMain[0];
        cls[clsStore] = opMain[0];
      end
      opCondJump: begin
        cls[clsJump] = 1'b1;
        cls[clsAlu]  = 1'b1;  // flag test needs an ALU slot
      end
      opLongJump: begin
        cls[clsJump] = 1'b1;
      end
      opBranchGroup: begin
        // subs 4..7 are undefined and stay unclassified
        cls[clsJump]  = brSub <= 3'd3;
        cls[clsIndir] = brSub == 3'd0 || brSub == 3'd3;  // indirect, return
        cls[clsStore] = brSub == 3'd1 || brSub == 3'd2;  // call pushes the link
      end
      opSys: begin
        cls[clsSys] = 1'b1;
      end
      opShortAlu: begin
        cls[clsAlu] = 1'b1;
      end
      opShortShift: begin
        cls[clsShift] = 1'b1;
      end
      opShortJump: begin
        cls[clsJump] = 1'b1;
      end
      default: begin
        cls = '0;
      end
    endcase
  end

endmodule

// ==== design/predecodeCtrl.sv ====
`timescale 1ns/1ns
// start detection, lane selects, counts, error flags and status strobes of the predecoder
module predecodeCtrl import predecodePkg::*; (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   bundleValid,
  input  logic [offW-1:0]        startOff,
  input  logic [nSlots-1:0]      slotEnd,
  input  logic [nSlots-1:0]      slotJump,
  output logic [nSlots-1:0]      instrSel,
  output logic [nSlots-1:0]      jumpSel,
  output logic                   capture,
  output logic                   outValid,
  output logic                   hasJumps,
  output logic                   error,
  output logic                   jumpError,
  output logic [nInstrLanes-1:0] instrEn,
  output logic [nJumpLanes-1:0]  jumpEn
);

  logic [nSlots-1:0]      prevEnd;
  logic [nSlots-1:0]      atOrAfter;
  logic [nSlots-1:0]      isStart;
  logic [nSlots-1:0]      endAhead;
  logic [offW-1:0]        instrCnt;  // 15 slots fit in an offset-wide count
  logic [offW-1:0]        jumpCnt;
  logic [nInstrLanes-1:0] nextInstrEn;
  logic [nJumpLanes-1:0]  nextJumpEn;

  // slot 0 always follows an end
  assign prevEnd = {slotEnd[nSlots-2:0], 1'b1};

  always_comb begin
    for (int k = 0; k < nSlots; k++) begin
      atOrAfter[k] = offW'(k) >= startOff;
    end
  end

  assign isStart = atOrAfter & prevEnd;

  // some end bit at this slot or later
  always_comb begin
    endAhead[nSlots-1] = slotEnd[nSlots-1];
    for (int k = nSlots - 2; k >= 0; k--) begin
      endAhead[k] = slotEnd[k] | endAhead[k+1];
    end
  end

  assign instrSel = isStart & endAhead;
  assign jumpSel  = instrSel & slotJump;

  always_comb begin
    instrCnt = '0;
    jumpCnt  = '0;
    for (int k = 0; k < nSlots; k++) begin
      instrCnt = instrCnt + offW'(instrSel[k]);
      jumpCnt  = jumpCnt + offW'(jumpSel[k]);
    end
  end

  // thermometer enables, saturate at the lane counts
  always_comb begin
    for (int n = 0; n < nInstrLanes; n++) begin
      nextInstrEn[n] = instrCnt > offW'(n);
    end
    for (int n = 0; n < nJumpLanes; n++) begin
      nextJumpEn[n] = jumpCnt > offW'(n);
    end
  end

  assign capture = bundleValid;  // compactors load on the same edge

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      outValid  <= 1'b0;
      instrEn   <= '0;
      jumpEn    <= '0;
      hasJumps  <= 1'b0;
      error     <= 1'b0;
      jumpError <= 1'b0;
    end else begin
      outValid <= bundleValid;  // one-cycle pulse
      if (bundleValid) begin
        instrEn   <= nextInstrEn;
        jumpEn    <= nextJumpEn;
        hasJumps  <= jumpCnt != '0;
        error     <= instrCnt > offW'(nInstrLanes) || startOff == '1;
        jumpError <= jumpCnt > offW'(nJumpLanes);
      end
    end
  end

endmodule

// ==== design/slotCompactor.sv ====
`timescale 1ns/1ns
// packs the selected slots in slot order into nLanes registered lanes, used for instrs and jumps
module slotCompactor import predecodePkg::*; #(
  parameter int nLanes = nInstrLanes
) (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic                          capture,
  input  logic [nSlots-1:0]             sel,
  input  logic [nSlots-1:0][instrW-1:0] slotData,
  input  logic [nSlots-1:0][clsW-1:0]   slotCls,
  output logic [nLanes-1:0][instrW-1:0] laneInstr,
  output logic [nLanes-1:0][offW-1:0]   laneOff,
  output logic [nLanes-1:0][clsW-1:0]   laneCls
);

  logic [nLanes-1:0][instrW-1:0] nextInstr;
  logic [nLanes-1:0][offW-1:0]   nextOff;
  logic [nLanes-1:0][clsW-1:0]   nextCls;
  logic [offW-1:0]               below;  // selected slots seen so far

  // slot k goes to lane n when it is selected and n selected slots precede it
  always_comb begin
    nextInstr = '0;
    nextOff   = '0;
    nextCls   = '0;
    below     = '0;
    for (int k = 0; k < nSlots; k++) begin
      for (int n = 0; n < nLanes; n++) begin
        if (sel[k] && below == offW'(n)) begin
          nextInstr[n] = slotData[k];
          nextOff[n]   = offW'(k);
          nextCls[n]   = slotCls[k];
        end
      end
      below = below + offW'(sel[k]);
    end
  end

  // empty lanes load zeros
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      laneInstr <= '0;
      laneOff   <= '0;
      laneCls   <= '0;
    end else if (capture) begin
      laneInstr <= nextInstr;
      laneOff   <= nextOff;
      laneCls   <= nextCls;
    end
  end

endmodule

// ==== design/predecoder.sv ====
`timescale 1ns/1ns
// fetch-bundle predecoder top, instantiate with a 256-bit bundle and a valid strobe
module predecoder import predecodePkg::*; (
  input  logic                               clk,
  input  logic                               rstN,
  input  logic                               bundleValid,
  input  logic [255:0]                       bundle,  // bit 255 unused
  input  logic [offW-1:0]                    startOff,
  output logic                               outValid,
  output logic [nInstrLanes-1:0]             instrEn,
  output logic [nInstrLanes-1:0][instrW-1:0] instrLane,
  output logic [nInstrLanes-1:0][offW-1:0]   offLane,
  output logic [nInstrLanes-1:0][clsW-1:0]   clsLane,
  output logic [nJumpLanes-1:0]              jumpEn,
  output logic [nJumpLanes-1:0][instrW-1:0]  jumpInstrLane,
  output logic [nJumpLanes-1:0][offW-1:0]    jumpOffLane,
  output logic [nJumpLanes-1:0][clsW-1:0]    jumpClsLane,
  output logic                               hasJumps,
  output logic                               error,
  output logic                               jumpError
);

  logic [nSlots*slotW+instrW-slotW-1:0] padData;  // three zero halfwords past slot 14
  logic [nSlots+2:0]                    padEnd;
  logic [nSlots-1:0]                    slotEnd;
  logic [nSlots-1:0][instrW-1:0]        slotData;
  logic [nSlots-1:0][clsW-1:0]          cls;
  logic [nSlots-1:0]                    slotJump;
  logic [nSlots-1:0]                    instrSel;
  logic [nSlots-1:0]                    jumpSel;
  logic                                 capture;

  assign slotEnd = bundle[nSlots*slotW +: nSlots];
  assign padData = {{(instrW - slotW){1'b0}}, bundle[nSlots*slotW-1:0]};
  assign padEnd  = {3'b0, slotEnd};

  for (genvar k = 0; k < nSlots; k++) begin : genSlot
    assign slotData[k] = padData[k*slotW +: instrW];
    assign slotJump[k] = cls[k][clsJump];

    instrClassifier classifier (
      .instr (slotData[k]),
      .magic (~padEnd[k +: 4]),
      .cls   (cls[k])
    );
  end

  predecodeCtrl ctrl (
    .clk         (clk),
    .rstN        (rstN),
    .bundleValid (bundleValid),
    .startOff    (startOff),
    .slotEnd     (slotEnd),
    .slotJump    (slotJump),
    .instrSel    (instrSel),
    .jumpSel     (jumpSel),
    .capture     (capture),
    .outValid    (outValid),
    .hasJumps    (hasJumps),
    .error       (error),
    .jumpError   (jumpError),
    .instrEn     (instrEn),
    .jumpEn      (jumpEn)
  );

  slotCompactor #(.nLanes(nInstrLanes)) instrCompactor (
    .clk       (clk),
    .rstN      (rstN),
    .capture   (capture),
    .sel       (instrSel),
    .slotData  (slotData),
    .slotCls   (cls),
    .laneInstr (instrLane),
    .laneOff   (offLane),
    .laneCls   (clsLane)
  );

  slotCompactor #(.nLanes(nJumpLanes)) jumpCompactor (
    .clk       (clk),
    .rstN      (rstN),
    .capture   (capture),
    .sel       (jumpSel),
    .slotData  (slotData),
    .slotCls   (cls),
    .laneInstr (jumpInstrLane),
    .laneOff   (jumpOffLane),
    .laneCls   (jumpClsLane)
  );

endmodule

// ==== tests/predecoder_assertions.sv ====
`timescale 1ns/1ns
// concurrent checks on the predecoder strobes and enables, attached to the DUT by bind
module predecoderAssertions import predecodePkg::*; (
  input logic                   clk,
  input logic                   rstN,
  input logic                   bundleValid,
  input logic                   outValid,
  input logic                   hasJumps,
  input logic [nInstrLanes-1:0] instrEn,
  input logic [nJumpLanes-1:0]  jumpEn
);

  int failCount = 0;  // failed assertions so far

  // no output pulse without a strobe the cycle before
  assert property (@(posedge clk) disable iff (!rstN) !bundleValid |=> !outValid)
    else begin
      $error("outValid high without bundleValid one cycle earlier");
      failCount++;
    end

  assert property (@(posedge clk) disable iff (!rstN) bundleValid |=> outValid)
    else begin
      $error("outValid missing one cycle after bundleValid");
      failCount++;
    end

  assert property (@(posedge clk) disable iff (!rstN) |jumpEn |-> hasJumps)
    else begin
      $error("jump lane enabled while hasJumps is low");
      failCount++;
    end

  // enables fill from lane 0 upward
  assert property (@(posedge clk) disable iff (!rstN)
                   (instrEn & (instrEn + nInstrLanes'(1))) == '0)
    else begin
      $error("instrEn is not thermometer shaped");
      failCount++;
    end

endmodule

// ==== tests/predecoderModel.svh ====
// rule model of the predecoder, included inside the testbench module after the package import
`ifndef PREDECODER_MODEL_SVH
`define PREDECODER_MODEL_SVH

// halfword k of the bundle, zero past the last slot
function automatic logic [slotW-1:0] halfAt(input logic [255:0] b, input int k);
  logic [slotW-1:0] h;
  h = '0;
  if (k < nSlots) begin
    h = b[k*slotW +: slotW];
  end
  return h;
endfunction

function automatic logic endAt(input logic [255:0] b, input int k);
  logic e;
  e = 1'b0;
  if (k < nSlots) begin
    e = b[nSlots*slotW + k];
  end
  return e;
endfunction

function automatic logic [instrW-1:0] instrAt(input logic [255:0] b, input int k);
  return {halfAt(b, k + 3), halfAt(b, k + 2), halfAt(b, k + 1), halfAt(b, k)};
endfunction

// starts at or after the offset that have an end bit somewhere ahead
function automatic logic [nSlots-1:0] countedStarts(input logic [255:0] b,
                                                    input logic [offW-1:0] off);
  logic [nSlots-1:0] s;
  logic              start;
  logic              ends;
  s = '0;
  for (int k = 0; k < nSlots; k++) begin
    start = k >= int'(off) && (k == 0 || endAt(b, k - 1));
    ends  = 1'b0;
    for (int j = k; j < nSlots; j++) begin
      ends = ends | endAt(b, j);
    end
    s[k] = start && ends;
  end
  return s;
endfunction

function automatic opGroupT groupOf(input logic [instrW-1:0] instr, input logic oneHalf);
  logic [7:0] op;
  logic [5:0] sub;
  op  = instr[7:0];
  sub = instr[5:0];
  if (oneHalf) begin
    if (sub <= 6'd15) return opShortAlu;
    if (sub >= 6'd48 && sub <= 6'd51) return opShortJump;
    if (sub <= 6'd31 && sub[0]) return opShortShift;
    return opNone;
  end
  if (op <= 8'd39) return op[2] ? opMul : opAlu;
  if (op >= 8'd40 && op <= 8'd45) return opShift;
  if (op >= 8'd46 && op <= 8'd51) return opCmp;
  if (op >= 8'd64 && op <= 8'd111) return opMem;
  if (op >= 8'd160 && op <= 8'd175) return opCondJump;
  if (op == 8'd180 || op == 8'd181) return opLongJump;
  if (op == 8'd182) return opBranchGroup;
  if (op == 8'd255) return opSys;
  return opNone;
endfunction

function automatic logic [clsW-1:0] clsOf(input logic [instrW-1:0] instr, input logic oneHalf);
  logic [clsW-1:0] c;
  logic [2:0]      br;
  c  = '0;
  br = instr[15:13];
  case (groupOf(instr, oneHalf))
    opAlu, opCmp, opShortAlu: c[clsAlu] = 1'b1;
    opMul: c[clsMul] = 1'b1;
    opShift, opShortShift: c[clsShift] = 1'b1;
    opMem: c[instr[0] ? clsStore : clsLoad] = 1'b1;
    opCondJump: begin
      c[clsJump] = 1'b1;
      c[clsAlu]  = 1'b1;
    end
    opLongJump, opShortJump: c[clsJump] = 1'b1;
    opBranchGroup: begin
      if (br == 3'd0 || br == 3'd3) begin  // indirect and return
        c[clsJump]  = 1'b1;
        c[clsIndir] = 1'b1;
      end else if (br == 3'd1 || br == 3'd2) begin  // calls
        c[clsJump]  = 1'b1;
        c[clsStore] = 1'b1;
      end
    end
    opSys: c[clsSys] = 1'b1;
    default: c = '0;
  endcase
  return c;
endfunction

`endif

// ==== tests/predecoderTb.sv ====
`timescale 1ns/1ns
// testbench for the predecoder, random bundles from a fixed seed checked against a rule model
module predecoderTb import predecodePkg::*; ();

  localparam int nBundles        = 400;
  localparam int cyclesPerBundle = 3;
  localparam int timeoutNs       = ((nBundles + 2) * cyclesPerBundle + 40) * 40;

  logic                               clk;
  logic                               rstN;
  logic                               bundleValid;
  logic [255:0]                       bundle;
  logic [offW-1:0]                    startOff;
  logic                               outValid;
  logic [nInstrLanes-1:0]             instrEn;
  logic [nInstrLanes-1:0][instrW-1:0] instrLane;
  logic [nInstrLanes-1:0][offW-1:0]   offLane;
  logic [nInstrLanes-1:0][clsW-1:0]   clsLane;
  logic [nJumpLanes-1:0]              jumpEn;
  logic [nJumpLanes-1:0][instrW-1:0]  jumpInstrLane;
  logic [nJumpLanes-1:0][offW-1:0]    jumpOffLane;
  logic [nJumpLanes-1:0][clsW-1:0]    jumpClsLane;
  logic                               hasJumps;
  logic                               error;
  logic                               jumpError;
  int                                 errCount = 0;
  int                                 checkCount = 0;

  `include "predecoderModel.svh"

  predecoder UUT (
    .clk(clk), .rstN(rstN), .bundleValid(bundleValid), .bundle(bundle), .startOff(startOff),
    .outValid(outValid), .instrEn(instrEn), .instrLane(instrLane), .offLane(offLane),
    .clsLane(clsLane), .jumpEn(jumpEn), .jumpInstrLane(jumpInstrLane),
    .jumpOffLane(jumpOffLane), .jumpClsLane(jumpClsLane), .hasJumps(hasJumps),
    .error(error), .jumpError(jumpError)
  );

  bind predecoder predecoderAssertions checks (
    .clk(clk), .rstN(rstN), .bundleValid(bundleValid), .outValid(outValid),
    .hasJumps(hasJumps), .instrEn(instrEn), .jumpEn(jumpEn)
  );

  always #20 clk = ~clk;

  task automatic checkEq(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
    checkCount++;
    if (expected !== actual) begin
      errCount++;
      $display("Mismatch %s: expected %h, actual %h at %0t", what, expected, actual, $time);
    end
  endtask

  task automatic checkLane(input string what, input logic [instrW-1:0] expInstr,
                           input int expOff, input logic [clsW-1:0] expCls,
                           input logic [instrW-1:0] actInstr, input logic [offW-1:0] actOff,
                           input logic [clsW-1:0] actCls);
    checkEq({what, " instr"}, expInstr, actInstr);
    checkEq({what, " off"}, 64'(expOff), 64'(actOff));
    checkEq({what, " cls"}, 64'(expCls), 64'(actCls));
  endtask

  task automatic checkIdle(input string what);
    checkEq({what, " outValid"}, 64'(0), 64'(outValid));
    checkEq({what, " instrEn"}, 64'(0), 64'(instrEn));
    checkEq({what, " jumpEn"}, 64'(0), 64'(jumpEn));
    checkEq({what, " flags"}, 64'(0), 64'({hasJumps, error, jumpError}));
    checkEq({what, " lanes"}, 64'(0),
            64'(|{instrLane, offLane, clsLane, jumpInstrLane, jumpOffLane, jumpClsLane}));
  endtask

  task automatic checkOutputs(input string what, input logic [255:0] b,
                              input logic [offW-1:0] off);
    logic [nSlots-1:0]      starts;
    logic [instrW-1:0]      instr;
    logic [clsW-1:0]        cls;
    logic [nInstrLanes-1:0] expInstrEn;
    logic [nJumpLanes-1:0]  expJumpEn;
    int                     nInstr;
    int                     nJump;
    starts = countedStarts(b, off);
    nInstr = 0;
    nJump  = 0;
    for (int k = 0; k < nSlots; k++) begin
      if (starts[k]) begin
        instr = instrAt(b, k);
        cls   = clsOf(instr, endAt(b, k));
        if (nInstr < nInstrLanes) begin
          checkLane($sformatf("%s lane %0d", what, nInstr), instr, k, cls,
                    instrLane[nInstr], offLane[nInstr], clsLane[nInstr]);
        end
        nInstr++;
        if (cls[clsJump]) begin
          if (nJump < nJumpLanes) begin
            checkLane($sformatf("%s jump lane %0d", what, nJump), instr, k, cls,
                      jumpInstrLane[nJump], jumpOffLane[nJump], jumpClsLane[nJump]);
          end
          nJump++;
        end
      end
    end
    // lanes past the count read as zero
    for (int n = nInstr; n < nInstrLanes; n++) begin
      checkLane($sformatf("%s empty lane %0d", what, n), '0, 0, '0,
                instrLane[n], offLane[n], clsLane[n]);
    end
    for (int n = nJump; n < nJumpLanes; n++) begin
      checkLane($sformatf("%s empty jump lane %0d", what, n), '0, 0, '0,
                jumpInstrLane[n], jumpOffLane[n], jumpClsLane[n]);
    end
    for (int n = 0; n < nInstrLanes; n++) begin
      expInstrEn[n] = nInstr > n;
    end
    for (int n = 0; n < nJumpLanes; n++) begin
      expJumpEn[n] = nJump > n;
    end
    checkEq({what, " instrEn"}, 64'(expInstrEn), 64'(instrEn));
    checkEq({what, " jumpEn"}, 64'(expJumpEn), 64'(jumpEn));
    checkEq({what, " hasJumps"}, 64'(nJump > 0), 64'(hasJumps));
    checkEq({what, " error"}, 64'(nInstr > nInstrLanes || off == 4'd15), 64'(error));
    checkEq({what, " jumpError"}, 64'(nJump > nJumpLanes), 64'(jumpError));
  endtask

  function automatic logic [7:0] pickOpcode();
    case ($urandom % 9)
      0: return 8'($urandom % 52);
      1: return 8'(64 + $urandom % 48);
      2: return 8'hff;
      3: return {2'($urandom), 6'($urandom % 16)};        // short alu
      4: return {2'($urandom), 6'(($urandom % 16) * 2 + 1)};  // short shift
      default: return 8'($urandom);
    endcase
  endfunction

  function automatic logic [7:0] pickJumpOpcode();
    case ($urandom % 4)
      0: return 8'(160 + $urandom % 16);
      1: return 8'(180 + $urandom % 2);
      2: return 8'd182;  // sub-field comes from the random upper bits
      default: return {2'($urandom), 6'(48 + $urandom % 4)};
    endcase
  endfunction

  // end density and jump share vary per bundle
  task automatic makeBundle(output logic [255:0] b, output logic [offW-1:0] off);
    int               endPct;
    int               jumpWeight;
    logic [slotW-1:0] hw;
    endPct     = $urandom % 9;
    jumpWeight = $urandom % 4;
    b          = '0;
    for (int k = 0; k < nSlots; k++) begin
      hw = 16'($urandom);
      if (($urandom % 4) < jumpWeight) begin
        hw[7:0] = pickJumpOpcode();
      end else if (($urandom % 8) != 0) begin
        hw[7:0] = pickOpcode();
      end
      b[k*slotW +: slotW]  = hw;
      b[nSlots*slotW + k] = ($urandom % 8) < endPct;
    end
    b[255] = 1'($urandom);  // ignored by the DUT
    off    = ($urandom % 2 == 0) ? 4'($urandom) : 4'd0;
  endtask

  task automatic sendBundle(input string what, input logic [255:0] b,
                            input logic [offW-1:0] off);
    @(posedge clk);
    bundleValid <= 1'b1;
    bundle      <= b;
    startOff    <= off;
    @(posedge clk);
    bundleValid <= 1'b0;
    bundle      <= ~b;
    startOff    <= ~off;
    @(negedge clk);
    checkEq({what, " outValid"}, 64'(1), 64'(outValid));
    checkOutputs(what, b, off);
    @(negedge clk);
    checkEq({what, " outValid low"}, 64'(0), 64'(outValid));
    checkOutputs({what, " held"}, b, off);  // results hold without a strobe
  endtask

  initial begin : watchdog
    #(timeoutNs);
    $display("Timeout: the run did not finish within %0d ns", timeoutNs);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    logic [255:0]    b;
    logic [offW-1:0] off;
    void'($urandom(32'hd123));
    clk         = 1'b0;
    rstN        = 1'b0;
    bundleValid = 1'b0;
    bundle      = '0;
    startOff    = '0;
    repeat (10) @(posedge clk);
    rstN <= 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    checkIdle("after reset");
    // fifteen one-halfword instrs overflow the lanes
    makeBundle(b, off);
    b[nSlots*slotW +: nSlots] = '1;
    sendBundle("all short", b, 4'd0);
    makeBundle(b, off);
    sendBundle("offset 15", b, 4'd15);
    for (int i = 0; i < nBundles; i++) begin
      makeBundle(b, off);
      sendBundle($sformatf("bundle %0d", i), b, off);
    end
    $display("checks: %0d, errors: %0d, assertion failures: %0d", checkCount, errCount,
             UUT.checks.failCount);
    if (errCount == 0 && UUT.checks.failCount == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+tests
design/predecodePkg.sv
design/instrClassifier.sv
design/predecodeCtrl.sv
design/slotCompactor.sv
design/predecoder.sv
tests/predecoder_assertions.sv
tests/predecoderTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the predecoder testbench with Verilator, nonzero exit on failure
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f list.f --top-module predecoderTb -o simPredecoder \
  || { echo "build failed"; exit 1; }
./obj_dir/simPredecoder > sim.log 2>&1 || echo "STATUS: FAIL" >> sim.log
cat sim.log
grep -q "STATUS: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "no pass status in the log"; exit 1; }
echo "simulation passed"
